//--- verilog/sram_perf_config.svh
`ifndef SRAM_PERF_CONFIG_SVH
`define SRAM_PERF_CONFIG_SVH

// Number of SRAM chips the words are striped over, a power of two.
`define SRAM_NUM_S 2

// Pins of one chip.
`define SRAM_ADDR_WIDTH 18
`define SRAM_DATA_WIDTH 16

// Entries per lane queue, a power of two so the pointers wrap on their own.
`define SRAM_QUEUE_DEPTH 4

// Width of every statistics counter.
`define SRAM_STAT_WIDTH 16

`endif

//--- verilog/sram_perf_pkg.sv
`default_nettype none

`include "sram_perf_config.svh"

package sram_perf_pkg;

  localparam int LANE_BITS = $clog2(`SRAM_NUM_S);
  localparam int WORD_ADDR_WIDTH = `SRAM_ADDR_WIDTH + LANE_BITS;

  typedef logic [WORD_ADDR_WIDTH-1:0] word_addr_t;
  typedef logic [`SRAM_DATA_WIDTH-1:0] data_t;
  typedef logic [`SRAM_STAT_WIDTH-1:0] stat_t;

  typedef struct packed {
    word_addr_t base;   // First word address.
    word_addr_t count;  // Words in the run, at least one.
    data_t      seed;
  } run_cfg_t;

  // Writes carry data, reads carry the low address bits for the checker.
  typedef union packed {
    data_t wr_data;
    data_t rd_tag;
  } req_payload_u;

  typedef struct packed {
    logic         is_write;
    word_addr_t   addr;
    req_payload_u payload;
  } sram_req_t;

  typedef struct packed {
    data_t data;
    data_t tag;
  } sram_rsp_t;

  typedef struct packed {
    stat_t cycles;
    stat_t writes;
    stat_t reads;
    stat_t errors;
  } perf_stats_t;

endpackage

`default_nettype wire

//--- verilog/sram_traffic_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_perf_config.svh"

module sram_traffic_gen import sram_perf_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  run_cfg_t               cfg,
  output logic                   busy,
  output logic                   done,
  output perf_stats_t            stats,
  output logic                   req_valid,
  input  logic                   req_ready,
  output sram_req_t              req,
  input  logic [`SRAM_NUM_S-1:0] rsp_valid,
  output logic [`SRAM_NUM_S-1:0] rsp_ready,
  input  sram_rsp_t              rsp [`SRAM_NUM_S],
  input  logic                   lanes_idle
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_DRAIN,
    ST_READ
  } state_t;

  state_t     state;
  run_cfg_t   cfg_q;
  word_addr_t addr_q;
  word_addr_t issued;   // Requests accepted in this phase.
  word_addr_t rsp_cnt;  // Read responses checked.
  logic       xfer;
  logic       last_issue;
  logic       rsp_hit;
  sram_rsp_t  rsp_sel;

  assign busy       = (state != ST_IDLE);
  assign req_valid  = (state == ST_WRITE) || (state == ST_READ && issued != cfg_q.count);
  assign xfer       = req_valid && req_ready;
  assign last_issue = (issued == cfg_q.count - 1'b1);

  always_comb begin
    req = '0;
    req.is_write = (state == ST_WRITE);
    req.addr = addr_q;
    if (state == ST_WRITE) begin
      req.payload.wr_data = addr_q[`SRAM_DATA_WIDTH-1:0] ^ cfg_q.seed;
    end else begin
      req.payload.rd_tag = addr_q[`SRAM_DATA_WIDTH-1:0];
    end
  end

  // Fixed priority, lowest lane first.
  always_comb begin
    rsp_ready = '0;
    rsp_hit = 1'b0;
    rsp_sel = rsp[0];
    for (int i = 0; i < `SRAM_NUM_S; i++) begin
      if (state == ST_READ && rsp_valid[i] && !rsp_hit) begin
        rsp_ready[i] = 1'b1;
        rsp_hit = 1'b1;
        rsp_sel = rsp[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && start) begin
      cfg_q  <= cfg;
      addr_q <= cfg.base;
    end else if (state == ST_WRITE && xfer && last_issue) begin
      addr_q <= cfg_q.base;  // Rewind for the read phase.
    end else if (xfer) begin
      addr_q <= addr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      done    <= 1'b0;
      stats   <= '0;
      issued  <= '0;
      rsp_cnt <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start) begin
            state        <= ST_WRITE;
            issued       <= '0;
            rsp_cnt      <= '0;
            stats.cycles <= stat_t'(1);  // The start edge counts.
            stats.writes <= '0;
            stats.reads  <= '0;
            stats.errors <= '0;
          end
        end
        ST_WRITE: begin
          if (xfer) begin
            stats.writes <= stats.writes + 1'b1;
            if (last_issue) begin
              state  <= ST_DRAIN;
              issued <= '0;
            end else begin
              issued <= issued + 1'b1;
            end
          end
        end
        ST_DRAIN: begin
          if (lanes_idle) state <= ST_READ;
        end
        ST_READ: begin
          if (xfer) issued <= issued + 1'b1;
          if (rsp_hit) begin
            rsp_cnt     <= rsp_cnt + 1'b1;
            stats.reads <= stats.reads + 1'b1;
            if (rsp_sel.data != (rsp_sel.tag ^ cfg_q.seed)) begin
              stats.errors <= stats.errors + 1'b1;
            end
            if (rsp_cnt == cfg_q.count - 1'b1) begin
              state <= ST_IDLE;
              done  <= 1'b1;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
      if (state != ST_IDLE) stats.cycles <= stats.cycles + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/sram_stripe_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_perf_config.svh"

module sram_stripe_queue import sram_perf_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  sram_req_t              req,
  output logic [`SRAM_NUM_S-1:0] lane_valid,
  input  logic [`SRAM_NUM_S-1:0] lane_ready,
  output sram_req_t              lane_req [`SRAM_NUM_S],
  output logic                   lanes_idle
);

  localparam int PW = $clog2(`SRAM_QUEUE_DEPTH);
  localparam logic [PW:0] FULL = (PW+1)'(`SRAM_QUEUE_DEPTH);

  sram_req_t              mem [`SRAM_NUM_S][`SRAM_QUEUE_DEPTH];
  logic [PW-1:0]          wr_ptr [`SRAM_NUM_S];
  logic [PW-1:0]          rd_ptr [`SRAM_NUM_S];
  logic [PW:0]            fill [`SRAM_NUM_S];
  logic [LANE_BITS-1:0]   tgt;
  logic [`SRAM_NUM_S-1:0] lane_push;
  logic [`SRAM_NUM_S-1:0] lane_pop;
  sram_req_t              push_req;

  assign tgt       = req.addr[LANE_BITS-1:0];
  assign req_ready = (fill[tgt] != FULL);  // Stall while the target lane is full.
  assign lane_pop  = lane_valid & lane_ready;

  always_comb begin
    push_req = req;
    push_req.addr = req.addr >> LANE_BITS;  // Lane address only.
    lanes_idle = &lane_ready;
    for (int i = 0; i < `SRAM_NUM_S; i++) begin
      lane_push[i] = req_valid && req_ready && (tgt == LANE_BITS'(i));
      lane_valid[i] = (fill[i] != '0);
      lane_req[i] = mem[i][rd_ptr[i]];
      if (fill[i] != '0) lanes_idle = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) mem[tgt][wr_ptr[tgt]] <= push_req;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `SRAM_NUM_S; i++) begin
        wr_ptr[i] <= '0;
        rd_ptr[i] <= '0;
        fill[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < `SRAM_NUM_S; i++) begin
        if (lane_push[i]) wr_ptr[i] <= wr_ptr[i] + 1'b1;
        if (lane_pop[i]) rd_ptr[i] <= rd_ptr[i] + 1'b1;
        case ({lane_push[i], lane_pop[i]})
          2'b10:   fill[i] <= fill[i] + 1'b1;
          2'b01:   fill[i] <= fill[i] - 1'b1;
          default: fill[i] <= fill[i];
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/sram_lane_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_perf_config.svh"

module sram_lane_ctrl import sram_perf_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        req_valid,
  output logic                        req_ready,
  input  sram_req_t                   req,
  output logic                        rsp_valid,
  input  logic                        rsp_ready,
  output sram_rsp_t                   rsp,
  output logic [`SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [`SRAM_DATA_WIDTH-1:0] sram_data,
  output logic                        sram_we_n,
  output logic                        sram_oe_n
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ1,
    ST_READ2,
    ST_HOLD
  } state_t;

  state_t state;
  data_t  wr_data_q;

  assign req_ready = (state == ST_IDLE);
  assign rsp_valid = (state == ST_HOLD);
  assign sram_we_n = (state != ST_WRITE);
  assign sram_oe_n = !(state == ST_READ1 || state == ST_READ2);

  // Bus is released whenever we_n is high.
  assign sram_data = (state == ST_WRITE) ? wr_data_q : {`SRAM_DATA_WIDTH{1'bz}};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (req_valid) state <= req.is_write ? ST_WRITE : ST_READ1;
        end
        ST_WRITE: state <= ST_IDLE;  // One cycle write pulse.
        ST_READ1: state <= ST_READ2;
        ST_READ2: state <= ST_HOLD;
        ST_HOLD: begin
          if (rsp_ready) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && req_valid) begin
      sram_addr <= req.addr[`SRAM_ADDR_WIDTH-1:0];
      wr_data_q <= req.payload.wr_data;
      rsp.tag   <= req.payload.rd_tag;
    end
    if (state == ST_READ2) rsp.data <= sram_data;  // Data settled after two cycles.
  end

endmodule

`default_nettype wire

//--- verilog/sram_perf_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_perf_config.svh"

module sram_perf_top import sram_perf_pkg::*; (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic                                          start,
  input  run_cfg_t                                      cfg,
  output logic                                          busy,
  output logic                                          done,
  output perf_stats_t                                   stats,
  output logic [`SRAM_NUM_S-1:0][`SRAM_ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [`SRAM_NUM_S-1:0][`SRAM_DATA_WIDTH-1:0] sram_data,
  output logic [`SRAM_NUM_S-1:0]                       sram_we_n,
  output logic [`SRAM_NUM_S-1:0]                       sram_oe_n
);

  logic                   req_valid;
  logic                   req_ready;
  sram_req_t              req;
  logic [`SRAM_NUM_S-1:0] lane_valid;
  logic [`SRAM_NUM_S-1:0] lane_ready;
  sram_req_t              lane_req [`SRAM_NUM_S];
  logic [`SRAM_NUM_S-1:0] rsp_valid;
  logic [`SRAM_NUM_S-1:0] rsp_ready;
  sram_rsp_t              rsp [`SRAM_NUM_S];
  logic                   lanes_idle;

  sram_traffic_gen gen0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg       (cfg),
    .busy      (busy),
    .done      (done),
    .stats     (stats),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .lanes_idle(lanes_idle)
  );

  sram_stripe_queue queue0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .lane_valid(lane_valid),
    .lane_ready(lane_ready),
    .lane_req  (lane_req),
    .lanes_idle(lanes_idle)
  );

  for (genvar i = 0; i < `SRAM_NUM_S; i++) begin : g_lane
    sram_lane_ctrl lane (
      .clk      (clk),
      .rst_n    (rst_n),
      .req_valid(lane_valid[i]),
      .req_ready(lane_ready[i]),
      .req      (lane_req[i]),
      .rsp_valid(rsp_valid[i]),
      .rsp_ready(rsp_ready[i]),
      .rsp      (rsp[i]),
      .sram_addr(sram_addr[i]),
      .sram_data(sram_data[i]),
      .sram_we_n(sram_we_n[i]),
      .sram_oe_n(sram_oe_n[i])
    );
  end

endmodule

`default_nettype wire

//--- sim/sram_async_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_perf_config.svh"

module sram_async_model (
  input  logic [`SRAM_ADDR_WIDTH-1:0] addr,
  inout  wire  [`SRAM_DATA_WIDTH-1:0] data,
  input  logic                        we_n,
  input  logic                        oe_n,
  input  logic                        fault_en,    // Flip bit 0 on reads of fault_addr.
  input  logic [`SRAM_ADDR_WIDTH-1:0] fault_addr,
  input  logic [`SRAM_ADDR_WIDTH-1:0] peek_addr,   // Backdoor port for the testbench.
  output logic [`SRAM_DATA_WIDTH-1:0] peek_data
);

  logic [`SRAM_DATA_WIDTH-1:0] mem [0:(1<<`SRAM_ADDR_WIDTH)-1];
  logic [`SRAM_DATA_WIDTH-1:0] rd_word;

  assign rd_word = mem[addr] ^ {{(`SRAM_DATA_WIDTH-1){1'b0}}, fault_en && (addr == fault_addr)};
  assign data = (!oe_n && we_n) ? rd_word : {`SRAM_DATA_WIDTH{1'bz}};
  assign peek_data = mem[peek_addr];

  // Write lands mid pulse, once address and data have settled.
  always @(negedge we_n) begin
    #5;
    if (!we_n) mem[addr] = data;
  end

endmodule

`default_nettype wire

//--- sim/sram_perf_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_perf_config.svh"

module sram_perf_props import sram_perf_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      req_valid,
  input logic      req_ready,
  input sram_req_t req,
  input logic      we_n,
  input logic      oe_n,
  input logic      bus_float  // High while nothing drives the data pins.
);

  int fail_count;

  a_we_oe: assert property (@(posedge clk) disable iff (!rst_n) we_n || oe_n)
    else begin
      fail_count++;
      $error("we_n and oe_n are low together");
    end

  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
      fail_count++;
      $error("request withdrawn or changed before its transfer");
    end

  // Outside a write only the chip may drive, and only with oe_n low.
  a_bus_idle: assert property (@(posedge clk) disable iff (!rst_n)
    we_n && oe_n |-> bus_float)
    else begin
      fail_count++;
      $error("data bus driven outside a write");
    end

endmodule

`default_nettype wire

//--- sim/sram_perf_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sram_perf_config.svh"

module sram_perf_tb import sram_perf_pkg::*; ();

  typedef logic [`SRAM_ADDR_WIDTH-1:0] lane_addr_t;

  typedef struct packed {
    int base;
    int count;
    int seed;
    int fault_en;
    int fault_addr;  // Global word address.
    int exp_errors;
  } row_t;

  localparam int N_ROWS = 6;
  // base, count, seed, fault_en, fault_addr, expected errors
  localparam row_t ROWS [N_ROWS] = '{
    '{0,       1,  'h0000, 0, 0,       0},
    '{5,       7,  'ha5a5, 0, 0,       0},
    '{100,     16, 'h1234, 1, 107,     1},
    '{100,     16, 'h4321, 1, 116,     0},
    '{3,       9,  'hffff, 1, 3,       1},
    '{'h7fff0, 16, 'h0f0f, 1, 'h7ffef, 0}
  };

  logic                                         clk;
  logic                                         rst_n;
  logic                                         start;
  run_cfg_t                                     cfg;
  logic                                         busy;
  logic                                         done;
  perf_stats_t                                  stats;
  logic [`SRAM_NUM_S-1:0][`SRAM_ADDR_WIDTH-1:0] sram_addr;
  wire  [`SRAM_NUM_S-1:0][`SRAM_DATA_WIDTH-1:0] sram_data;
  logic [`SRAM_NUM_S-1:0]                       sram_we_n;
  logic [`SRAM_NUM_S-1:0]                       sram_oe_n;
  logic [`SRAM_NUM_S-1:0]                       fault_en;
  lane_addr_t                                   fault_la;
  lane_addr_t                                   peek_addr;
  logic [`SRAM_NUM_S-1:0][`SRAM_DATA_WIDTH-1:0] peek_data;
  int                                           prop_fails [`SRAM_NUM_S];
  int                                           prop_total;
  int                                           checks;
  int                                           errors;

  sram_perf_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .cfg      (cfg),
    .busy     (busy),
    .done     (done),
    .stats    (stats),
    .sram_addr(sram_addr),
    .sram_data(sram_data),
    .sram_we_n(sram_we_n),
    .sram_oe_n(sram_oe_n)
  );

  for (genvar i = 0; i < `SRAM_NUM_S; i++) begin : g_mem
    sram_async_model model (
      .addr      (sram_addr[i]),
      .data      (sram_data[i]),
      .we_n      (sram_we_n[i]),
      .oe_n      (sram_oe_n[i]),
      .fault_en  (fault_en[i]),
      .fault_addr(fault_la),
      .peek_addr (peek_addr),
      .peek_data (peek_data[i])
    );
    assign prop_fails[i] = dut0.g_lane[i].lane.props0.fail_count;
  end

  // The queue instance only sees the generator handshake, pins are tied off.
  bind sram_stripe_queue sram_perf_props props0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req      (req),
    .we_n     (1'b1),
    .oe_n     (1'b1),
    .bus_float(1'b1)
  );

  bind sram_lane_ctrl sram_perf_props props0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req      (req),
    .we_n     (sram_we_n),
    .oe_n     (sram_oe_n),
    .bus_float(sram_data === {`SRAM_DATA_WIDTH{1'bz}})
  );

  always #10 clk = ~clk;

  function automatic int total_words();
    int n;
    n = 0;
    for (int r = 0; r < N_ROWS; r++) n += ROWS[r].count;
    return n;
  endfunction

  function automatic string stats_str(input perf_stats_t s);
    return $sformatf("cycles=%0d writes=%0d reads=%0d errors=%0d",
                     s.cycles, s.writes, s.reads, s.errors);
  endfunction

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic check_word(input string name, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %04h, actual %04h", name, exp, act);
    end
  endtask

  task automatic check_stats(input string name, input perf_stats_t exp, input perf_stats_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %s, actual %s", name, stats_str(exp), stats_str(act));
    end
  endtask

  // Word at global address A is A xor seed, in lane A mod NUM_S at A div NUM_S.
  task automatic check_memory(input int r, input row_t row);
    int    lane;
    data_t exp_word;
    for (int a = row.base; a < row.base + row.count; a++) begin
      lane = a % `SRAM_NUM_S;
      peek_addr = lane_addr_t'(a / `SRAM_NUM_S);
      #1;
      exp_word = data_t'(a) ^ data_t'(row.seed);
      check_word($sformatf("row %0d word %0h", r, a), exp_word, peek_data[lane]);
    end
  endtask

  task automatic run_row(input int r);
    row_t        row;
    perf_stats_t exp_stats;
    int          edges;
    bit          finished;
    row = ROWS[r];
    @(posedge clk);
    #2;
    fault_en = '0;
    if (row.fault_en != 0) fault_en[row.fault_addr % `SRAM_NUM_S] = 1'b1;
    fault_la = lane_addr_t'(row.fault_addr / `SRAM_NUM_S);
    cfg.base = word_addr_t'(row.base);
    cfg.count = word_addr_t'(row.count);
    cfg.seed = data_t'(row.seed);
    start = 1'b1;
    @(posedge clk);  // Start is accepted here.
    edges = 1;
    #1;
    check_flag($sformatf("row %0d busy", r), 1'b1, busy);
    #1;
    start = 1'b0;
    finished = 1'b0;
    while (!finished) begin
      @(posedge clk);
      edges++;
      #1;
      if (done) finished = 1'b1;
      else check_flag($sformatf("row %0d busy", r), 1'b1, busy);
    end
    exp_stats.cycles = stat_t'(edges);
    exp_stats.writes = stat_t'(row.count);
    exp_stats.reads = stat_t'(row.count);
    exp_stats.errors = stat_t'(row.exp_errors);
    check_stats($sformatf("row %0d stats", r), exp_stats, stats);
    @(posedge clk);
    #1;
    check_flag($sformatf("row %0d done pulse", r), 1'b0, done);
    check_memory(r, row);
    check_stats($sformatf("row %0d stats held", r), exp_stats, stats);
  endtask

  initial begin : watchdog
    int limit;
    limit = 10 + 200 + 20 * total_words();
    repeat (limit) @(posedge clk);
    $display("Timeout: the runs did not finish within %0d cycles", limit);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    cfg = '0;
    fault_en = '0;
    fault_la = '0;
    peek_addr = '0;
    checks = 0;
    errors = 0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_flag("reset busy", 1'b0, busy);
    check_flag("reset done", 1'b0, done);
    for (int i = 0; i < `SRAM_NUM_S; i++) begin
      check_flag($sformatf("reset we_n lane %0d", i), 1'b1, sram_we_n[i]);
      check_flag($sformatf("reset oe_n lane %0d", i), 1'b1, sram_oe_n[i]);
    end
    for (int r = 0; r < N_ROWS; r++) run_row(r);
    prop_total = dut0.queue0.props0.fail_count;
    for (int i = 0; i < `SRAM_NUM_S; i++) prop_total += prop_fails[i];
    $display("Checks: %0d, value errors: %0d, property failures: %0d",
             checks, errors, prop_total);
    if (errors == 0 && prop_total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/sram_perf_pkg.sv
verilog/sram_traffic_gen.sv
verilog/sram_stripe_queue.sv
verilog/sram_lane_ctrl.sv
verilog/sram_perf_top.sv
sim/sram_async_model.sv
sim/sram_perf_props.sv
sim/sram_perf_tb.sv

//--- Makefile
# Verilator build and run for the striped SRAM tester.
# Any variable can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= sram_perf_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verilog/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, a header or the file list changes.
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
